// File: common/core_types_pkg.sv
// Core-wide widths for physical registers, ROB indices and PRF writeback banks; import where needed
package core_types_pkg;

	// ----------------------------------------------------------------------
	// Physical register file

	// Width of a physical register index
	localparam int LOG_PR_COUNT = 6;

	// Number of writeback banks, one writeback lane per bank
	localparam int PRF_BANK_COUNT = 4;

	// Width of a bank number
	// The bank of a register is its low bits, the rest form its upper part
	localparam int LOG_PRF_BANK_COUNT = 2;

	// ----------------------------------------------------------------------
	// Reorder buffer

	// Width of a ROB index
	localparam int LOG_ROB_ENTRIES = 6;

endpackage

// File: common/alu_iq_pkg.sv
// ALU opcode type and issue queue sizing defaults; imported by the issue queue blocks
package alu_iq_pkg;

	// ALU opcodes carried through the queue untouched
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101
	} alu_op_t;

	// Default queue depth
	localparam int DEF_IQ_ENTRIES = 4;

	// Default number of dispatch lanes
	localparam int DEF_DISPATCH_WIDTH = 4;

endpackage

// File: verilog/wb_wakeup_match.sv
// Matches waiting queue operands against the banked writeback bus; used inside alu_reg_iq
module wb_wakeup_match
	import core_types_pkg::*;
	import alu_iq_pkg::*;
#(
	parameter int IQ_ENTRIES = DEF_IQ_ENTRIES
) (
	input  logic [IQ_ENTRIES-1:0] entry_valid,
	input  logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_a_pr,
	input  logic [IQ_ENTRIES-1:0] entry_a_ready,
	input  logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_b_pr,
	input  logic [IQ_ENTRIES-1:0] entry_b_ready,
	input  logic [PRF_BANK_COUNT-1:0] wb_valid_by_bank,
	input  logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,
	output logic [IQ_ENTRIES-1:0] woken_a,
	output logic [IQ_ENTRIES-1:0] woken_b
);

	// Only the lane of the register's own bank can carry it
	function automatic logic pr_written(input logic [LOG_PR_COUNT-1:0] pr);
		logic [LOG_PRF_BANK_COUNT-1:0] bank;

		bank = pr[LOG_PRF_BANK_COUNT-1:0];
		return wb_valid_by_bank[bank]
			&& (wb_upper_pr_by_bank[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
	endfunction

	// Ready operands never report woken, so woken means forwardable
	always_comb begin
		for (int k = 0; k < IQ_ENTRIES; k++) begin
			woken_a[k] = entry_valid[k] & ~entry_a_ready[k] & pr_written(entry_a_pr[k]);
			woken_b[k] = entry_valid[k] & ~entry_b_ready[k] & pr_written(entry_b_pr[k]);
		end
	end

endmodule

// File: alu_reg_iq/iq_dispatch_alloc.sv
// Dispatch lane ready and slot allocation for the compacting issue queue; used inside alu_reg_iq
module iq_dispatch_alloc
	import alu_iq_pkg::*;
#(
	parameter int IQ_ENTRIES = DEF_IQ_ENTRIES,
	parameter int DISPATCH_WIDTH = DEF_DISPATCH_WIDTH
) (
	input  logic [IQ_ENTRIES-1:0] entry_valid,
	input  logic [IQ_ENTRIES-1:0] issue_sel,
	input  logic [DISPATCH_WIDTH-1:0] dispatch_valid_by_lane,
	output logic [DISPATCH_WIDTH-1:0] dispatch_ready_by_lane,
	output logic [DISPATCH_WIDTH-1:0] lane_write_en,
	output logic [DISPATCH_WIDTH-1:0][$clog2(IQ_ENTRIES)-1:0] lane_slot
);

	localparam int SLOT_W = $clog2(IQ_ENTRIES);

	always_comb begin
		int survivors;
		int free_slots;
		int valid_below;

		// Occupied entries are contiguous from slot 0
		survivors = 0;
		for (int k = 0; k < IQ_ENTRIES; k++) begin
			survivors += int'(entry_valid[k]);
		end

		// The slot issued this cycle is free for dispatch
		if (|issue_sel) begin
			survivors -= 1;
		end
		free_slots = IQ_ENTRIES - survivors;

		// Lanes fill in order behind the compacted survivors
		valid_below = 0;
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			dispatch_ready_by_lane[i] = free_slots > valid_below;
			lane_write_en[i] = dispatch_valid_by_lane[i] & dispatch_ready_by_lane[i];
			lane_slot[i] = SLOT_W'(survivors + valid_below);
			valid_below += int'(dispatch_valid_by_lane[i]);
		end
	end

endmodule

// File: alu_reg_iq/iq_entry_array.sv
// Age-ordered entry storage with wakeup, issue removal and compaction; used inside alu_reg_iq
module iq_entry_array
	import core_types_pkg::*;
	import alu_iq_pkg::*;
#(
	parameter int IQ_ENTRIES = DEF_IQ_ENTRIES,
	parameter int DISPATCH_WIDTH = DEF_DISPATCH_WIDTH
) (
	input  logic CLK,
	input  logic nRST,

	// New entries from accepted lanes
	input  logic [DISPATCH_WIDTH-1:0] lane_write_en,
	input  logic [DISPATCH_WIDTH-1:0][$clog2(IQ_ENTRIES)-1:0] lane_slot,
	input  alu_op_t [DISPATCH_WIDTH-1:0] dispatch_op_by_lane,
	input  logic [DISPATCH_WIDTH-1:0][LOG_PR_COUNT-1:0] dispatch_a_pr_by_lane,
	input  logic [DISPATCH_WIDTH-1:0] dispatch_a_ready_by_lane,
	input  logic [DISPATCH_WIDTH-1:0][LOG_PR_COUNT-1:0] dispatch_b_pr_by_lane,
	input  logic [DISPATCH_WIDTH-1:0] dispatch_b_ready_by_lane,
	input  logic [DISPATCH_WIDTH-1:0][LOG_PR_COUNT-1:0] dispatch_dest_pr_by_lane,
	input  logic [DISPATCH_WIDTH-1:0][LOG_ROB_ENTRIES-1:0] dispatch_rob_index_by_lane,

	// Wakeup and issue of the current entries
	input  logic [IQ_ENTRIES-1:0] woken_a,
	input  logic [IQ_ENTRIES-1:0] woken_b,
	input  logic [IQ_ENTRIES-1:0] issue_sel,

	// Entries, slot 0 oldest
	output logic [IQ_ENTRIES-1:0] entry_valid,
	output alu_op_t [IQ_ENTRIES-1:0] entry_op,
	output logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_a_pr,
	output logic [IQ_ENTRIES-1:0] entry_a_ready,
	output logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_b_pr,
	output logic [IQ_ENTRIES-1:0] entry_b_ready,
	output logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_dest_pr,
	output logic [IQ_ENTRIES-1:0][LOG_ROB_ENTRIES-1:0] entry_rob_index
);

	logic [IQ_ENTRIES-1:0] next_valid;
	alu_op_t [IQ_ENTRIES-1:0] next_op;
	logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] next_a_pr;
	logic [IQ_ENTRIES-1:0] next_a_ready;
	logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] next_b_pr;
	logic [IQ_ENTRIES-1:0] next_b_ready;
	logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] next_dest_pr;
	logic [IQ_ENTRIES-1:0][LOG_ROB_ENTRIES-1:0] next_rob_index;

	// ----------------------------------------------------------------------
	// Next queue contents

	always_comb begin
		logic shifting;
		int src;

		// Slots at and above the issued one pull from the slot above
		shifting = 1'b0;
		for (int k = 0; k < IQ_ENTRIES; k++) begin
			shifting = shifting | issue_sel[k];
			src = (shifting && k < IQ_ENTRIES - 1) ? k + 1 : k;
			next_valid[k] = entry_valid[src] & ~(shifting && k == IQ_ENTRIES - 1);
			next_op[k] = entry_op[src];
			next_a_pr[k] = entry_a_pr[src];
			next_a_ready[k] = entry_a_ready[src] | woken_a[src];
			next_b_pr[k] = entry_b_pr[src];
			next_b_ready[k] = entry_b_ready[src] | woken_b[src];
			next_dest_pr[k] = entry_dest_pr[src];
			next_rob_index[k] = entry_rob_index[src];
		end

		// New ops land behind the survivors
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			if (lane_write_en[i]) begin
				next_valid[lane_slot[i]] = 1'b1;
				next_op[lane_slot[i]] = dispatch_op_by_lane[i];
				next_a_pr[lane_slot[i]] = dispatch_a_pr_by_lane[i];
				next_a_ready[lane_slot[i]] = dispatch_a_ready_by_lane[i];
				next_b_pr[lane_slot[i]] = dispatch_b_pr_by_lane[i];
				next_b_ready[lane_slot[i]] = dispatch_b_ready_by_lane[i];
				next_dest_pr[lane_slot[i]] = dispatch_dest_pr_by_lane[i];
				next_rob_index[lane_slot[i]] = dispatch_rob_index_by_lane[i];
			end
		end
	end

	// ----------------------------------------------------------------------
	// State

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			entry_valid <= '0;
			entry_a_ready <= '0;
			entry_b_ready <= '0;
		end else begin
			entry_valid <= next_valid;
			entry_a_ready <= next_a_ready;
			entry_b_ready <= next_b_ready;
		end
	end

	always_ff @(posedge CLK) begin
		entry_op <= next_op;
		entry_a_pr <= next_a_pr;
		entry_b_pr <= next_b_pr;
		entry_dest_pr <= next_dest_pr;
		entry_rob_index <= next_rob_index;
	end

endmodule

// File: alu_reg_iq/iq_issue_select.sv
// Oldest-ready issue selection with forward and PRF request forming; used inside alu_reg_iq
module iq_issue_select
	import core_types_pkg::*;
	import alu_iq_pkg::*;
#(
	parameter int IQ_ENTRIES = DEF_IQ_ENTRIES
) (
	input  logic pipeline_ready,
	input  logic [IQ_ENTRIES-1:0] entry_valid,
	input  alu_op_t [IQ_ENTRIES-1:0] entry_op,
	input  logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_a_pr,
	input  logic [IQ_ENTRIES-1:0] entry_a_ready,
	input  logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_b_pr,
	input  logic [IQ_ENTRIES-1:0] entry_b_ready,
	input  logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_dest_pr,
	input  logic [IQ_ENTRIES-1:0][LOG_ROB_ENTRIES-1:0] entry_rob_index,
	input  logic [IQ_ENTRIES-1:0] woken_a,
	input  logic [IQ_ENTRIES-1:0] woken_b,

	output logic [IQ_ENTRIES-1:0] issue_sel,
	output logic issue_valid,
	output alu_op_t issue_op,
	output logic issue_a_forward,
	output logic [LOG_PRF_BANK_COUNT-1:0] issue_a_bank,
	output logic issue_b_forward,
	output logic [LOG_PRF_BANK_COUNT-1:0] issue_b_bank,
	output logic [LOG_PR_COUNT-1:0] issue_dest_pr,
	output logic [LOG_ROB_ENTRIES-1:0] issue_rob_index,
	output logic prf_req_a_valid,
	output logic [LOG_PR_COUNT-1:0] prf_req_a_pr,
	output logic prf_req_b_valid,
	output logic [LOG_PR_COUNT-1:0] prf_req_b_pr
);

	logic [IQ_ENTRIES-1:0] eligible;

	// Operands count as ready if already marked or woken this cycle
	assign eligible = entry_valid & (entry_a_ready | woken_a) & (entry_b_ready | woken_b);

	// Lowest set bit is the oldest eligible entry
	assign issue_sel = pipeline_ready ? (eligible & (~eligible + 1'b1)) : '0;
	assign issue_valid = |issue_sel;

	always_comb begin
		issue_op = ALU_ADD;
		issue_a_forward = 1'b0;
		issue_b_forward = 1'b0;
		prf_req_a_pr = '0;
		prf_req_b_pr = '0;
		issue_dest_pr = '0;
		issue_rob_index = '0;
		for (int k = 0; k < IQ_ENTRIES; k++) begin
			if (issue_sel[k]) begin
				issue_op = entry_op[k];
				issue_a_forward = woken_a[k];
				issue_b_forward = woken_b[k];
				prf_req_a_pr = entry_a_pr[k];
				prf_req_b_pr = entry_b_pr[k];
				issue_dest_pr = entry_dest_pr[k];
				issue_rob_index = entry_rob_index[k];
			end
		end
	end

	// A forwarded operand comes off the bypass, not the PRF
	assign prf_req_a_valid = issue_valid & ~issue_a_forward;
	assign prf_req_b_valid = issue_valid & ~issue_b_forward;
	assign issue_a_bank = prf_req_a_pr[LOG_PRF_BANK_COUNT-1:0];
	assign issue_b_bank = prf_req_b_pr[LOG_PRF_BANK_COUNT-1:0];

endmodule

// File: alu_reg_iq/alu_reg_iq.sv
// ALU register-register issue queue with registered inputs and outputs; instantiate in the core
module alu_reg_iq
	import core_types_pkg::*;
	import alu_iq_pkg::*;
#(
	parameter int IQ_ENTRIES = DEF_IQ_ENTRIES,
	parameter int DISPATCH_WIDTH = DEF_DISPATCH_WIDTH
) (
	input  logic CLK,
	input  logic nRST,

	// Dispatch lanes
	input  logic [DISPATCH_WIDTH-1:0] dispatch_valid_by_lane,
	input  alu_op_t [DISPATCH_WIDTH-1:0] dispatch_op_by_lane,
	input  logic [DISPATCH_WIDTH-1:0][LOG_PR_COUNT-1:0] dispatch_a_pr_by_lane,
	input  logic [DISPATCH_WIDTH-1:0] dispatch_a_ready_by_lane,
	input  logic [DISPATCH_WIDTH-1:0][LOG_PR_COUNT-1:0] dispatch_b_pr_by_lane,
	input  logic [DISPATCH_WIDTH-1:0] dispatch_b_ready_by_lane,
	input  logic [DISPATCH_WIDTH-1:0][LOG_PR_COUNT-1:0] dispatch_dest_pr_by_lane,
	input  logic [DISPATCH_WIDTH-1:0][LOG_ROB_ENTRIES-1:0] dispatch_rob_index_by_lane,
	output logic [DISPATCH_WIDTH-1:0] dispatch_ready_by_lane,

	// ALU pipeline back-pressure
	input  logic pipeline_ready,

	// Writeback bus, one lane per bank
	input  logic [PRF_BANK_COUNT-1:0] wb_valid_by_bank,
	input  logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,

	// Issue to the ALU pipeline
	output logic issue_valid,
	output alu_op_t issue_op,
	output logic issue_a_forward,
	output logic [LOG_PRF_BANK_COUNT-1:0] issue_a_bank,
	output logic issue_b_forward,
	output logic [LOG_PRF_BANK_COUNT-1:0] issue_b_bank,
	output logic [LOG_PR_COUNT-1:0] issue_dest_pr,
	output logic [LOG_ROB_ENTRIES-1:0] issue_rob_index,

	// Register read requests to the PRF
	output logic prf_req_a_valid,
	output logic [LOG_PR_COUNT-1:0] prf_req_a_pr,
	output logic prf_req_b_valid,
	output logic [LOG_PR_COUNT-1:0] prf_req_b_pr
);

	// ----------------------------------------------------------------------
	// Registered inputs

	logic [DISPATCH_WIDTH-1:0] dispatch_valid_q;
	alu_op_t [DISPATCH_WIDTH-1:0] dispatch_op_q;
	logic [DISPATCH_WIDTH-1:0][LOG_PR_COUNT-1:0] dispatch_a_pr_q;
	logic [DISPATCH_WIDTH-1:0] dispatch_a_ready_q;
	logic [DISPATCH_WIDTH-1:0][LOG_PR_COUNT-1:0] dispatch_b_pr_q;
	logic [DISPATCH_WIDTH-1:0] dispatch_b_ready_q;
	logic [DISPATCH_WIDTH-1:0][LOG_PR_COUNT-1:0] dispatch_dest_pr_q;
	logic [DISPATCH_WIDTH-1:0][LOG_ROB_ENTRIES-1:0] dispatch_rob_index_q;
	logic pipeline_ready_q;
	logic [PRF_BANK_COUNT-1:0] wb_valid_q;
	logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] wb_upper_pr_q;

	// Queue state and block results
	logic [IQ_ENTRIES-1:0] entry_valid;
	alu_op_t [IQ_ENTRIES-1:0] entry_op;
	logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_a_pr;
	logic [IQ_ENTRIES-1:0] entry_a_ready;
	logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_b_pr;
	logic [IQ_ENTRIES-1:0] entry_b_ready;
	logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0] entry_dest_pr;
	logic [IQ_ENTRIES-1:0][LOG_ROB_ENTRIES-1:0] entry_rob_index;
	logic [IQ_ENTRIES-1:0] woken_a;
	logic [IQ_ENTRIES-1:0] woken_b;
	logic [IQ_ENTRIES-1:0] issue_sel;
	logic [DISPATCH_WIDTH-1:0] lane_write_en;
	logic [DISPATCH_WIDTH-1:0][$clog2(IQ_ENTRIES)-1:0] lane_slot;

	// Outputs ahead of their register
	logic [DISPATCH_WIDTH-1:0] dispatch_ready_d;
	logic issue_valid_d;
	alu_op_t issue_op_d;
	logic issue_a_forward_d;
	logic [LOG_PRF_BANK_COUNT-1:0] issue_a_bank_d;
	logic issue_b_forward_d;
	logic [LOG_PRF_BANK_COUNT-1:0] issue_b_bank_d;
	logic [LOG_PR_COUNT-1:0] issue_dest_pr_d;
	logic [LOG_ROB_ENTRIES-1:0] issue_rob_index_d;
	logic prf_req_a_valid_d;
	logic [LOG_PR_COUNT-1:0] prf_req_a_pr_d;
	logic prf_req_b_valid_d;
	logic [LOG_PR_COUNT-1:0] prf_req_b_pr_d;

	// ----------------------------------------------------------------------
	// Queue blocks

	iq_dispatch_alloc #(
		.IQ_ENTRIES(IQ_ENTRIES),
		.DISPATCH_WIDTH(DISPATCH_WIDTH)
	) u_dispatch_alloc (
		.entry_valid(entry_valid),
		.issue_sel(issue_sel),
		.dispatch_valid_by_lane(dispatch_valid_q),
		.dispatch_ready_by_lane(dispatch_ready_d),
		.lane_write_en(lane_write_en),
		.lane_slot(lane_slot)
	);

	iq_entry_array #(
		.IQ_ENTRIES(IQ_ENTRIES),
		.DISPATCH_WIDTH(DISPATCH_WIDTH)
	) u_entry_array (
		.CLK(CLK),
		.nRST(nRST),
		.lane_write_en(lane_write_en),
		.lane_slot(lane_slot),
		.dispatch_op_by_lane(dispatch_op_q),
		.dispatch_a_pr_by_lane(dispatch_a_pr_q),
		.dispatch_a_ready_by_lane(dispatch_a_ready_q),
		.dispatch_b_pr_by_lane(dispatch_b_pr_q),
		.dispatch_b_ready_by_lane(dispatch_b_ready_q),
		.dispatch_dest_pr_by_lane(dispatch_dest_pr_q),
		.dispatch_rob_index_by_lane(dispatch_rob_index_q),
		.woken_a(woken_a),
		.woken_b(woken_b),
		.issue_sel(issue_sel),
		.entry_valid(entry_valid),
		.entry_op(entry_op),
		.entry_a_pr(entry_a_pr),
		.entry_a_ready(entry_a_ready),
		.entry_b_pr(entry_b_pr),
		.entry_b_ready(entry_b_ready),
		.entry_dest_pr(entry_dest_pr),
		.entry_rob_index(entry_rob_index)
	);

	wb_wakeup_match #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) u_wakeup_match (
		.entry_valid(entry_valid),
		.entry_a_pr(entry_a_pr),
		.entry_a_ready(entry_a_ready),
		.entry_b_pr(entry_b_pr),
		.entry_b_ready(entry_b_ready),
		.wb_valid_by_bank(wb_valid_q),
		.wb_upper_pr_by_bank(wb_upper_pr_q),
		.woken_a(woken_a),
		.woken_b(woken_b)
	);

	iq_issue_select #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) u_issue_select (
		.pipeline_ready(pipeline_ready_q),
		.entry_valid(entry_valid),
		.entry_op(entry_op),
		.entry_a_pr(entry_a_pr),
		.entry_a_ready(entry_a_ready),
		.entry_b_pr(entry_b_pr),
		.entry_b_ready(entry_b_ready),
		.entry_dest_pr(entry_dest_pr),
		.entry_rob_index(entry_rob_index),
		.woken_a(woken_a),
		.woken_b(woken_b),
		.issue_sel(issue_sel),
		.issue_valid(issue_valid_d),
		.issue_op(issue_op_d),
		.issue_a_forward(issue_a_forward_d),
		.issue_a_bank(issue_a_bank_d),
		.issue_b_forward(issue_b_forward_d),
		.issue_b_bank(issue_b_bank_d),
		.issue_dest_pr(issue_dest_pr_d),
		.issue_rob_index(issue_rob_index_d),
		.prf_req_a_valid(prf_req_a_valid_d),
		.prf_req_a_pr(prf_req_a_pr_d),
		.prf_req_b_valid(prf_req_b_valid_d),
		.prf_req_b_pr(prf_req_b_pr_d)
	);

	// ----------------------------------------------------------------------
	// Boundary registers

	// Valids and handshake bits
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			dispatch_valid_q <= '0;
			pipeline_ready_q <= 1'b0;
			wb_valid_q <= '0;
			dispatch_ready_by_lane <= '0;
			issue_valid <= 1'b0;
			prf_req_a_valid <= 1'b0;
			prf_req_b_valid <= 1'b0;
		end else begin
			dispatch_valid_q <= dispatch_valid_by_lane;
			pipeline_ready_q <= pipeline_ready;
			wb_valid_q <= wb_valid_by_bank;
			dispatch_ready_by_lane <= dispatch_ready_d;
			issue_valid <= issue_valid_d;
			prf_req_a_valid <= prf_req_a_valid_d;
			prf_req_b_valid <= prf_req_b_valid_d;
		end
	end

	// Payload, only meaningful alongside its valid
	always_ff @(posedge CLK) begin
		dispatch_op_q <= dispatch_op_by_lane;
		dispatch_a_pr_q <= dispatch_a_pr_by_lane;
		dispatch_a_ready_q <= dispatch_a_ready_by_lane;
		dispatch_b_pr_q <= dispatch_b_pr_by_lane;
		dispatch_b_ready_q <= dispatch_b_ready_by_lane;
		dispatch_dest_pr_q <= dispatch_dest_pr_by_lane;
		dispatch_rob_index_q <= dispatch_rob_index_by_lane;
		wb_upper_pr_q <= wb_upper_pr_by_bank;
		issue_op <= issue_op_d;
		issue_a_forward <= issue_a_forward_d;
		issue_a_bank <= issue_a_bank_d;
		issue_b_forward <= issue_b_forward_d;
		issue_b_bank <= issue_b_bank_d;
		issue_dest_pr <= issue_dest_pr_d;
		issue_rob_index <= issue_rob_index_d;
		prf_req_a_pr <= prf_req_a_pr_d;
		prf_req_b_pr <= prf_req_b_pr_d;
	end

endmodule

// File: dv/alu_reg_iq_checks.sv
// Output checks of the ALU issue queue against the testbench model; instantiated beside the DUT
module alu_reg_iq_checks
	import core_types_pkg::*;
	import alu_iq_pkg::*;
#(
	parameter int DISPATCH_WIDTH = DEF_DISPATCH_WIDTH
) (
	input  logic CLK,

	// DUT outputs
	input  logic [DISPATCH_WIDTH-1:0] dispatch_ready_by_lane,
	input  logic issue_valid,
	input  alu_op_t issue_op,
	input  logic issue_a_forward,
	input  logic [LOG_PRF_BANK_COUNT-1:0] issue_a_bank,
	input  logic issue_b_forward,
	input  logic [LOG_PRF_BANK_COUNT-1:0] issue_b_bank,
	input  logic [LOG_PR_COUNT-1:0] issue_dest_pr,
	input  logic [LOG_ROB_ENTRIES-1:0] issue_rob_index,
	input  logic prf_req_a_valid,
	input  logic [LOG_PR_COUNT-1:0] prf_req_a_pr,
	input  logic prf_req_b_valid,
	input  logic [LOG_PR_COUNT-1:0] prf_req_b_pr,

	// Expected values from the model
	input  logic [DISPATCH_WIDTH-1:0] exp_ready,
	input  logic exp_valid,
	input  alu_op_t exp_op,
	input  logic [LOG_PR_COUNT-1:0] exp_a_pr,
	input  logic exp_a_forward,
	input  logic [LOG_PR_COUNT-1:0] exp_b_pr,
	input  logic exp_b_forward,
	input  logic [LOG_PR_COUNT-1:0] exp_dest_pr,
	input  logic [LOG_ROB_ENTRIES-1:0] exp_rob_index,
	output int error_count
);
	timeunit 1ns;
	timeprecision 100ps;

	initial error_count = 0;

	task automatic mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		error_count++;
	endtask

	// Outputs settle at the rising edge, so the falling edge sees them stable
	always @(negedge CLK) begin
		assert (dispatch_ready_by_lane === exp_ready)
			else mismatch("dispatch_ready_by_lane", exp_ready, dispatch_ready_by_lane);
		assert (issue_valid === exp_valid) else mismatch("issue_valid", exp_valid, issue_valid);
		assert (prf_req_a_valid === (exp_valid & ~exp_a_forward))
			else mismatch("prf_req_a_valid", exp_valid & ~exp_a_forward, prf_req_a_valid);
		assert (prf_req_b_valid === (exp_valid & ~exp_b_forward))
			else mismatch("prf_req_b_valid", exp_valid & ~exp_b_forward, prf_req_b_valid);
		if (exp_valid) begin
			assert (issue_op === exp_op) else mismatch("issue_op", exp_op, issue_op);
			assert (issue_a_forward === exp_a_forward)
				else mismatch("issue_a_forward", exp_a_forward, issue_a_forward);
			assert (issue_b_forward === exp_b_forward)
				else mismatch("issue_b_forward", exp_b_forward, issue_b_forward);
			// Bank is the low bits of the operand register
			assert (issue_a_bank === exp_a_pr[LOG_PRF_BANK_COUNT-1:0])
				else mismatch("issue_a_bank", exp_a_pr[LOG_PRF_BANK_COUNT-1:0], issue_a_bank);
			assert (issue_b_bank === exp_b_pr[LOG_PRF_BANK_COUNT-1:0])
				else mismatch("issue_b_bank", exp_b_pr[LOG_PRF_BANK_COUNT-1:0], issue_b_bank);
			assert (issue_dest_pr === exp_dest_pr)
				else mismatch("issue_dest_pr", exp_dest_pr, issue_dest_pr);
			assert (issue_rob_index === exp_rob_index)
				else mismatch("issue_rob_index", exp_rob_index, issue_rob_index);
			if (!exp_a_forward) begin
				assert (prf_req_a_pr === exp_a_pr) else mismatch("prf_req_a_pr", exp_a_pr, prf_req_a_pr);
			end
			if (!exp_b_forward) begin
				assert (prf_req_b_pr === exp_b_pr) else mismatch("prf_req_b_pr", exp_b_pr, prf_req_b_pr);
			end
		end
	end

endmodule

// File: dv/alu_reg_iq_tb.sv
// Testbench for the ALU register-register issue queue with a reference model; simulation top
module alu_reg_iq_tb
	import core_types_pkg::*;
	import alu_iq_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int IQ = DEF_IQ_ENTRIES;
	localparam int DW = DEF_DISPATCH_WIDTH;
	localparam int UPPER_W = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;
	localparam int RAND_CYCLES = 200;
	// Budget per test with its drain and a margin
	localparam int CYCLE_LIMIT = 10 + 50 + 60 + 60 + 60 + (RAND_CYCLES + 60) + 50;

	typedef struct packed {
		alu_op_t op;
		logic [LOG_PR_COUNT-1:0] a_pr;
		logic a_ready;
		logic [LOG_PR_COUNT-1:0] b_pr;
		logic b_ready;
		logic [LOG_PR_COUNT-1:0] dest_pr;
		logic [LOG_ROB_ENTRIES-1:0] rob;
	} uop_t;

	logic CLK;
	logic nRST;
	logic [DW-1:0] dispatch_valid_by_lane;
	alu_op_t [DW-1:0] dispatch_op_by_lane;
	logic [DW-1:0][LOG_PR_COUNT-1:0] dispatch_a_pr_by_lane;
	logic [DW-1:0] dispatch_a_ready_by_lane;
	logic [DW-1:0][LOG_PR_COUNT-1:0] dispatch_b_pr_by_lane;
	logic [DW-1:0] dispatch_b_ready_by_lane;
	logic [DW-1:0][LOG_PR_COUNT-1:0] dispatch_dest_pr_by_lane;
	logic [DW-1:0][LOG_ROB_ENTRIES-1:0] dispatch_rob_index_by_lane;
	logic [DW-1:0] dispatch_ready_by_lane;
	logic pipeline_ready;
	logic [PRF_BANK_COUNT-1:0] wb_valid_by_bank;
	logic [PRF_BANK_COUNT-1:0][UPPER_W-1:0] wb_upper_pr_by_bank;
	logic issue_valid;
	alu_op_t issue_op;
	logic issue_a_forward;
	logic [LOG_PRF_BANK_COUNT-1:0] issue_a_bank;
	logic issue_b_forward;
	logic [LOG_PRF_BANK_COUNT-1:0] issue_b_bank;
	logic [LOG_PR_COUNT-1:0] issue_dest_pr;
	logic [LOG_ROB_ENTRIES-1:0] issue_rob_index;
	logic prf_req_a_valid;
	logic [LOG_PR_COUNT-1:0] prf_req_a_pr;
	logic prf_req_b_valid;
	logic [LOG_PR_COUNT-1:0] prf_req_b_pr;

	// Model state with slot 0 oldest and inputs as the DUT registered them
	uop_t model_iq[$];
	uop_t in_uop_q [DW];
	logic [DW-1:0] in_valid_q;
	logic in_pready_q;
	logic [PRF_BANK_COUNT-1:0] wb_valid_q;
	logic [PRF_BANK_COUNT-1:0][UPPER_W-1:0] wb_upper_q;
	logic exp_valid;
	logic [DW-1:0] exp_ready;
	uop_t exp_uop;
	logic exp_a_forward;
	logic exp_b_forward;

	int check_errors;
	int tb_errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int accepted = 0;
	int dut_issues = 0;
	int rob_next = 0;
	int cycle_count = 0;
	integer seed;

	alu_reg_iq #(
		.IQ_ENTRIES(IQ),
		.DISPATCH_WIDTH(DW)
	) u_alu_reg_iq (.*);

	alu_reg_iq_checks #(
		.DISPATCH_WIDTH(DW)
	) u_checks (
		.CLK(CLK),
		.dispatch_ready_by_lane(dispatch_ready_by_lane),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_a_forward(issue_a_forward),
		.issue_a_bank(issue_a_bank),
		.issue_b_forward(issue_b_forward),
		.issue_b_bank(issue_b_bank),
		.issue_dest_pr(issue_dest_pr),
		.issue_rob_index(issue_rob_index),
		.prf_req_a_valid(prf_req_a_valid),
		.prf_req_a_pr(prf_req_a_pr),
		.prf_req_b_valid(prf_req_b_valid),
		.prf_req_b_pr(prf_req_b_pr),
		.exp_ready(exp_ready),
		.exp_valid(exp_valid),
		.exp_op(exp_uop.op),
		.exp_a_pr(exp_uop.a_pr),
		.exp_a_forward(exp_a_forward),
		.exp_b_pr(exp_uop.b_pr),
		.exp_b_forward(exp_b_forward),
		.exp_dest_pr(exp_uop.dest_pr),
		.exp_rob_index(exp_uop.rob),
		.error_count(check_errors)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(negedge CLK) begin
		if (issue_valid === 1'b1) begin
			dut_issues++;
		end
	end

	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	// ----------------------------------------------------------------------
	// Reference model

	// A bank lane carries the register whose low bits name that bank
	function automatic logic written_back(input logic [LOG_PR_COUNT-1:0] pr);
		logic [LOG_PRF_BANK_COUNT-1:0] bank;

		bank = pr[LOG_PRF_BANK_COUNT-1:0];
		return wb_valid_q[bank] && wb_upper_q[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
	endfunction

	task automatic model_reset();
		model_iq.delete();
		in_valid_q = '0;
		in_pready_q = 1'b0;
		wb_valid_q = '0;
		exp_valid = 1'b0;
		exp_ready = '0;
		exp_a_forward = 1'b0;
		exp_b_forward = 1'b0;
	endtask

	// One clock edge of the queue that predicts the registered outputs
	task automatic model_step();
		int sel;
		int free_slots;
		int valid_below;

		sel = -1;
		for (int k = 0; k < model_iq.size(); k++) begin
			if (sel < 0 && in_pready_q
					&& (model_iq[k].a_ready || written_back(model_iq[k].a_pr))
					&& (model_iq[k].b_ready || written_back(model_iq[k].b_pr))) begin
				sel = k;
			end
		end
		exp_valid = sel >= 0;
		if (sel >= 0) begin
			exp_uop = model_iq[sel];
			exp_a_forward = !model_iq[sel].a_ready && written_back(model_iq[sel].a_pr);
			exp_b_forward = !model_iq[sel].b_ready && written_back(model_iq[sel].b_pr);
		end

		// Issued slot counts as free for this cycle's lanes
		free_slots = IQ - model_iq.size() + (sel >= 0 ? 1 : 0);
		valid_below = 0;
		for (int i = 0; i < DW; i++) begin
			exp_ready[i] = free_slots > valid_below;
			valid_below += int'(in_valid_q[i]);
		end

		for (int k = 0; k < model_iq.size(); k++) begin
			model_iq[k].a_ready = model_iq[k].a_ready || written_back(model_iq[k].a_pr);
			model_iq[k].b_ready = model_iq[k].b_ready || written_back(model_iq[k].b_pr);
		end
		if (sel >= 0) begin
			model_iq.delete(sel);
		end
		for (int i = 0; i < DW; i++) begin
			if (in_valid_q[i] && exp_ready[i]) begin
				model_iq.push_back(in_uop_q[i]);
				accepted++;
			end
		end

		// Capture what the input registers take at this edge
		for (int i = 0; i < DW; i++) begin
			in_uop_q[i].op = dispatch_op_by_lane[i];
			in_uop_q[i].a_pr = dispatch_a_pr_by_lane[i];
			in_uop_q[i].a_ready = dispatch_a_ready_by_lane[i];
			in_uop_q[i].b_pr = dispatch_b_pr_by_lane[i];
			in_uop_q[i].b_ready = dispatch_b_ready_by_lane[i];
			in_uop_q[i].dest_pr = dispatch_dest_pr_by_lane[i];
			in_uop_q[i].rob = dispatch_rob_index_by_lane[i];
		end
		in_valid_q = dispatch_valid_by_lane;
		in_pready_q = pipeline_ready;
		wb_valid_q = wb_valid_by_bank;
		wb_upper_q = wb_upper_pr_by_bank;
	endtask

	// ----------------------------------------------------------------------
	// Stimulus helpers

	// Dispatch and writeback valids last one cycle
	task automatic cycle();
		@(posedge CLK);
		model_step();
		#1;
		dispatch_valid_by_lane = '0;
		wb_valid_by_bank = '0;
	endtask

	task automatic put_lane(input int lane, input alu_op_t op,
			input logic [LOG_PR_COUNT-1:0] a_pr, input logic a_rdy,
			input logic [LOG_PR_COUNT-1:0] b_pr, input logic b_rdy);
		dispatch_valid_by_lane[lane] = 1'b1;
		dispatch_op_by_lane[lane] = op;
		dispatch_a_pr_by_lane[lane] = a_pr;
		dispatch_a_ready_by_lane[lane] = a_rdy;
		dispatch_b_pr_by_lane[lane] = b_pr;
		dispatch_b_ready_by_lane[lane] = b_rdy;
		dispatch_dest_pr_by_lane[lane] = LOG_PR_COUNT'(rob_next);
		dispatch_rob_index_by_lane[lane] = LOG_ROB_ENTRIES'(rob_next);
		rob_next++;
	endtask

	task automatic write_back(input logic [LOG_PR_COUNT-1:0] pr);
		wb_valid_by_bank[pr[LOG_PRF_BANK_COUNT-1:0]] = 1'b1;
		wb_upper_pr_by_bank[pr[LOG_PRF_BANK_COUNT-1:0]] = pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
	endtask

	// Sweep writebacks over every register until the model queue is empty
	task automatic drain();
		int sweep;

		pipeline_ready = 1'b1;
		sweep = 0;
		while (model_iq.size() != 0 || in_valid_q != '0) begin
			wb_valid_by_bank = '1;
			for (int b = 0; b < PRF_BANK_COUNT; b++) begin
				wb_upper_pr_by_bank[b] = UPPER_W'(sweep);
			end
			sweep++;
			cycle();
		end
		repeat (2) cycle();
	endtask

	task automatic finish_test(input string name);
		int errs;

		errs = check_errors + tb_errors - errors_at_start;
		tests_run++;
		if (errs == 0) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errs);
		end
		errors_at_start = check_errors + tb_errors;
	endtask

	// ----------------------------------------------------------------------
	// Tests

	initial begin
		logic [31:0] r;

		seed = 32;
		nRST = 1'b0;
		pipeline_ready = 1'b0;
		dispatch_valid_by_lane = '0;
		for (int i = 0; i < DW; i++) begin
			dispatch_op_by_lane[i] = ALU_ADD;
		end
		dispatch_a_pr_by_lane = '0;
		dispatch_a_ready_by_lane = '0;
		dispatch_b_pr_by_lane = '0;
		dispatch_b_ready_by_lane = '0;
		dispatch_dest_pr_by_lane = '0;
		dispatch_rob_index_by_lane = '0;
		wb_valid_by_bank = '0;
		wb_upper_pr_by_bank = '0;
		model_reset();
		repeat (5) @(posedge CLK);
		#1;
		nRST = 1'b1;
		repeat (3) cycle();
		finish_test("reset");

		// Ready ops leave in dispatch order
		pipeline_ready = 1'b1;
		put_lane(0, ALU_ADD, 6'h04, 1'b1, 6'h05, 1'b1);
		put_lane(1, ALU_SUB, 6'h06, 1'b1, 6'h07, 1'b1);
		put_lane(2, ALU_XOR, 6'h08, 1'b1, 6'h0b, 1'b1);
		cycle();
		put_lane(0, ALU_SLT, 6'h0c, 1'b1, 6'h0d, 1'b1);
		cycle();
		drain();
		finish_test("in_order_issue");

		// 0x0a shares the upper bits of 0x09 on another bank
		put_lane(0, ALU_OR, 6'h09, 1'b0, 6'h11, 1'b1);
		repeat (3) cycle();
		write_back(6'h0a);
		repeat (3) cycle();
		write_back(6'h09);
		repeat (3) cycle();
		drain();
		finish_test("wakeup_forward");

		// Younger ready op passes an older blocked one
		put_lane(0, ALU_AND, 6'h14, 1'b1, 6'h12, 1'b0);
		put_lane(1, ALU_SLL, 6'h15, 1'b1, 6'h16, 1'b1);
		repeat (4) cycle();
		write_back(6'h12);
		repeat (3) cycle();
		drain();
		finish_test("oldest_ready_first");

		// Queue fills and wakes while the pipeline stalls
		pipeline_ready = 1'b0;
		put_lane(0, ALU_ADD, 6'h21, 1'b0, 6'h22, 1'b1);
		put_lane(1, ALU_SUB, 6'h23, 1'b1, 6'h24, 1'b1);
		put_lane(2, ALU_SRL, 6'h25, 1'b1, 6'h26, 1'b1);
		put_lane(3, ALU_SRA, 6'h27, 1'b1, 6'h28, 1'b1);
		repeat (2) cycle();
		put_lane(0, ALU_OR, 6'h29, 1'b1, 6'h2a, 1'b1);
		put_lane(1, ALU_OR, 6'h2b, 1'b1, 6'h2c, 1'b1);
		write_back(6'h21);
		repeat (6) cycle();
		drain();
		finish_test("back_pressure");

		// Four lanes into an empty queue and then a random mix
		pipeline_ready = 1'b0;
		for (int i = 0; i < DW; i++) begin
			put_lane(i, ALU_XOR, LOG_PR_COUNT'(i), 1'b1, LOG_PR_COUNT'(i + 8), 1'b1);
		end
		repeat (4) cycle();
		repeat (RAND_CYCLES) begin
			for (int i = 0; i < DW; i++) begin
				r = $random(seed);
				if (r[19]) begin
					put_lane(i, alu_op_t'({1'b0, r[2:0]}), r[8:3], r[10:9] != 2'b00,
						r[16:11], r[18:17] != 2'b00);
				end
			end
			for (int b = 0; b < PRF_BANK_COUNT; b++) begin
				r = $random(seed);
				wb_valid_by_bank[b] = r[1:0] == 2'b00;
				wb_upper_pr_by_bank[b] = r[UPPER_W+1:2];
			end
			r = $random(seed);
			pipeline_ready = r[1:0] != 2'b00;
			cycle();
		end
		drain();
		assert (dut_issues == accepted) else begin
			$display("FAIL at %0t: issue count expected %0d, got %0d", $time, accepted,
				dut_issues);
			tb_errors++;
		end
		finish_test("full_queue_random");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			check_errors + tb_errors);
		if (tests_failed == 0 && check_errors + tb_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: compile.f
common/core_types_pkg.sv
common/alu_iq_pkg.sv
verilog/wb_wakeup_match.sv
alu_reg_iq/iq_dispatch_alloc.sv
alu_reg_iq/iq_entry_array.sv
alu_reg_iq/iq_issue_select.sv
alu_reg_iq/alu_reg_iq.sv
dv/alu_reg_iq_checks.sv
dv/alu_reg_iq_tb.sv
